// ==== Makefile ====
VERILATOR ?= verilator
TB_TOP    ?= tb_dino_paint
RTL_TOP   ?= dino_paint_top
FILELIST  ?= dino_paint.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= All checks passed
VFLAGS    ?= --binary --timing --assert

RTL_SRCS = dino_paint_pkg.sv sprite_rom.sv paint_element.sv frame_buffer.sv \
           apb_paint_regs.sv dino_paint_top.sv

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TB_TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TB_TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) --lint-only --top-module $(RTL_TOP) $(RTL_SRCS)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== apb_paint_regs.sv ====
`timescale 1ns/1ps

module apb_paint_regs
  import dino_paint_pkg::*;
(
  input  logic                         clk_33m,
  input  logic                         rst,
  input  logic        [APB_AW-1:0]     paddr,
  input  logic                         psel,
  input  logic                         penable,
  input  logic                         pwrite,
  input  logic        [APB_DW-1:0]     pwdata,
  input  logic                         finished,
  input  logic        [PALETTE_W-1:0]  rd_data,
  output logic        [APB_DW-1:0]     prdata,
  output logic                         pready,
  output logic                         pslverr,
  output logic                         start,
  output logic        [COOR_WIDTH-1:0] sprite_x,
  output logic        [COOR_WIDTH-1:0] sprite_y,
  output logic signed [COOR_WIDTH:0]   frame_x,
  output logic signed [COOR_WIDTH:0]   frame_y,
  output logic        [COOR_WIDTH-1:0] width,
  output logic        [COOR_WIDTH-1:0] height,
  output logic        [FB_AW-1:0]      rd_addr
);

  logic access;
  logic fb_hit;
  logic reg_hit;
  logic fb_read;
  logic fb_wait;   // Pixel read data arrives next cycle
  logic wr_ok;
  logic busy;
  logic done;

  assign access  = psel && penable;
  assign fb_hit  = paddr >= FB_BASE;
  assign reg_hit = (paddr == REG_CTRL) || (paddr == REG_STATUS) ||
                   (paddr == REG_SPRITE_XY) || (paddr == REG_FRAME_XY) ||
                   (paddr == REG_SIZE);
  assign fb_read = fb_hit && !pwrite;

  // One wait state on pixel reads only
  always_ff @(posedge clk_33m) begin
    if (rst) fb_wait <= 1'b0;
    else     fb_wait <= access && fb_read && !fb_wait;
  end

  assign pready  = access && !(fb_read && !fb_wait);
  assign pslverr = access && !(reg_hit || fb_read); // Includes writes to the window

  assign rd_addr = paddr[FB_AW+1:2];

  // Geometry is frozen during a paint
  assign wr_ok = access && pwrite && !busy;
  assign start = wr_ok && (paddr == REG_CTRL) && pwdata[0];

  always_ff @(posedge clk_33m) begin
    if (rst) begin
      sprite_x <= '0;
      sprite_y <= '0;
      frame_x  <= '0;
      frame_y  <= '0;
      width    <= '0;
      height   <= '0;
    end else if (wr_ok) begin
      case (paddr)
        REG_SPRITE_XY: begin
          sprite_x <= pwdata[7:0];
          sprite_y <= pwdata[15:8];
        end
        REG_FRAME_XY: begin
          frame_x <= $signed(pwdata[8:0]);
          frame_y <= $signed(pwdata[24:16]);
        end
        REG_SIZE: begin
          width  <= pwdata[7:0];
          height <= pwdata[15:8];
        end
        default: ;
      endcase
    end
  end

  // Busy from start until the painter drains, done is sticky
  always_ff @(posedge clk_33m) begin
    if (rst) begin
      busy <= 1'b0;
      done <= 1'b0;
    end else if (start) begin
      busy <= 1'b1;
      done <= 1'b0;
    end else if (busy && finished) begin
      busy <= 1'b0;
      done <= 1'b1;
    end
  end

  always_comb begin
    prdata = '0;
    if (fb_hit) begin
      prdata = APB_DW'(rd_data);
    end else begin
      case (paddr)
        REG_STATUS:    prdata = {30'b0, done, busy};
        REG_SPRITE_XY: prdata = {16'b0, sprite_y, sprite_x};
        REG_FRAME_XY:  prdata = {7'b0, frame_y, 7'b0, frame_x};
        REG_SIZE:      prdata = {16'b0, height, width};
        default:       prdata = '0; // CTRL and unmapped read as zero
      endcase
    end
  end

endmodule

// ==== dino_paint.f ====
+incdir+.
dino_paint_pkg.sv
sprite_rom.sv
paint_element.sv
frame_buffer.sv
apb_paint_regs.sv
dino_paint_top.sv
tb_dino_paint.sv

// ==== dino_paint_pkg.sv ====
package dino_paint_pkg;

  // Geometry
  localparam int COOR_WIDTH    = 8;   // Sprite coordinates and sizes, unsigned
  localparam int FRAME_WIDTH   = 128;
  localparam int FRAME_HEIGHT  = 64;
  localparam int SPRITE_WIDTH  = 32;
  localparam int SPRITE_HEIGHT = 16;

  // Memory sizes
  localparam int ROM_AW    = 9;   // SPRITE_WIDTH * SPRITE_HEIGHT entries
  localparam int FB_AW     = 13;  // Row * FRAME_WIDTH + column
  localparam int PALETTE_W = 2;

  // APB bus
  localparam int APB_AW = 16;
  localparam int APB_DW = 32;

  // Register map, byte addresses
  localparam logic [APB_AW-1:0] REG_CTRL      = 16'h0000;  // Bit 0 start, write only
  localparam logic [APB_AW-1:0] REG_STATUS    = 16'h0004;  // Bit 0 busy, bit 1 done
  localparam logic [APB_AW-1:0] REG_SPRITE_XY = 16'h0008;
  localparam logic [APB_AW-1:0] REG_FRAME_XY  = 16'h000C;  // Signed x and y
  localparam logic [APB_AW-1:0] REG_SIZE      = 16'h0010;

  // Pixel window, one word per pixel
  localparam logic [APB_AW-1:0] FB_BASE = 16'h8000;

endpackage

// ==== dino_paint_top.sv ====
`timescale 1ns/1ps

module dino_paint_top
  import dino_paint_pkg::*;
(
  input  logic              clk_33m,
  input  logic              rst,
  input  logic [APB_AW-1:0] paddr,
  input  logic              psel,
  input  logic              penable,
  input  logic              pwrite,
  input  logic [APB_DW-1:0] pwdata,
  output logic [APB_DW-1:0] prdata,
  output logic              pready,
  output logic              pslverr
);

  logic                         start;
  logic                         finished;
  logic        [COOR_WIDTH-1:0] sprite_x;
  logic        [COOR_WIDTH-1:0] sprite_y;
  logic signed [COOR_WIDTH:0]   frame_x;
  logic signed [COOR_WIDTH:0]   frame_y;
  logic        [COOR_WIDTH-1:0] width;
  logic        [COOR_WIDTH-1:0] height;

  logic [ROM_AW-1:0]    rom_addr;
  logic [PALETTE_W-1:0] rom_data;
  logic                 wr_en;
  logic [FB_AW-1:0]     wr_addr;
  logic [PALETTE_W-1:0] wr_data;
  logic [FB_AW-1:0]     rd_addr;
  logic [PALETTE_W-1:0] rd_data;

  apb_paint_regs u_regs (
    .clk_33m  (clk_33m),
    .rst      (rst),
    .paddr    (paddr),
    .psel     (psel),
    .penable  (penable),
    .pwrite   (pwrite),
    .pwdata   (pwdata),
    .finished (finished),
    .rd_data  (rd_data),
    .prdata   (prdata),
    .pready   (pready),
    .pslverr  (pslverr),
    .start    (start),
    .sprite_x (sprite_x),
    .sprite_y (sprite_y),
    .frame_x  (frame_x),
    .frame_y  (frame_y),
    .width    (width),
    .height   (height),
    .rd_addr  (rd_addr)
  );

  paint_element u_paint (
    .clk_33m  (clk_33m),
    .rst      (rst),
    .start    (start),
    .sprite_x (sprite_x),
    .sprite_y (sprite_y),
    .frame_x  (frame_x),
    .frame_y  (frame_y),
    .width    (width),
    .height   (height),
    .rom_data (rom_data),
    .rom_addr (rom_addr),
    .wr_en    (wr_en),
    .wr_addr  (wr_addr),
    .wr_data  (wr_data),
    .finished (finished)
  );

  sprite_rom u_rom (
    .clk_33m (clk_33m),
    .addr    (rom_addr),
    .data    (rom_data)
  );

  frame_buffer u_fb (
    .clk_33m (clk_33m),
    .wr_en   (wr_en),
    .wr_addr (wr_addr),
    .wr_data (wr_data),
    .rd_addr (rd_addr),
    .rd_data (rd_data)
  );

endmodule

// ==== frame_buffer.sv ====
`timescale 1ns/1ps

module frame_buffer
  import dino_paint_pkg::*;
(
  input  logic                 clk_33m,
  input  logic                 wr_en,
  input  logic [FB_AW-1:0]     wr_addr,
  input  logic [PALETTE_W-1:0] wr_data,
  input  logic [FB_AW-1:0]     rd_addr,
  output logic [PALETTE_W-1:0] rd_data
);

  localparam int FB_DEPTH = FRAME_WIDTH * FRAME_HEIGHT;

  logic [PALETTE_W-1:0] mem [FB_DEPTH];

  // Blank frame at power up
  initial begin
    for (int i = 0; i < FB_DEPTH; i++) begin
      mem[i] = '0;
    end
  end

  // Painter port
  always_ff @(posedge clk_33m) begin
    if (wr_en) mem[wr_addr] <= wr_data;
  end

  // Host port, one cycle read
  always_ff @(posedge clk_33m) begin
    rd_data <= mem[rd_addr];
  end

endmodule

// ==== paint_element.sv ====
`timescale 1ns/1ps

module paint_element
  import dino_paint_pkg::*;
(
  input  logic                         clk_33m,
  input  logic                         rst,
  input  logic                         start,
  input  logic        [COOR_WIDTH-1:0] sprite_x,
  input  logic        [COOR_WIDTH-1:0] sprite_y,
  input  logic signed [COOR_WIDTH:0]   frame_x,
  input  logic signed [COOR_WIDTH:0]   frame_y,
  input  logic        [COOR_WIDTH-1:0] width,
  input  logic        [COOR_WIDTH-1:0] height,
  input  logic        [PALETTE_W-1:0]  rom_data,
  output logic        [ROM_AW-1:0]     rom_addr,
  output logic                         wr_en,
  output logic        [FB_AW-1:0]      wr_addr,
  output logic        [PALETTE_W-1:0]  wr_data,
  output logic                         finished
);

  logic                  run;    // Walker is on a valid pixel
  logic                  armed;  // Stage one still holds work
  logic [COOR_WIDTH-1:0] x;
  logic [COOR_WIDTH-1:0] y;

  logic                  v_d1;
  logic                  v_d2;
  logic [COOR_WIDTH-1:0] x_d1;
  logic [COOR_WIDTH-1:0] y_d1;
  logic [COOR_WIDTH-1:0] x_d2;
  logic [COOR_WIDTH-1:0] y_d2;

  logic        [COOR_WIDTH:0]   sheet_x;
  logic        [COOR_WIDTH:0]   sheet_y;
  logic signed [COOR_WIDTH+1:0] fx;
  logic signed [COOR_WIDTH+1:0] fy;
  logic                         in_frame;

  // Raster walk over the element
  always_ff @(posedge clk_33m) begin
    if (rst) begin
      run   <= 1'b0;
      armed <= 1'b0;
      x     <= '0;
      y     <= '0;
    end else begin
      armed <= run | start;
      if (start) begin
        x   <= '0;
        y   <= '0;
        run <= (width != '0) && (height != '0); // Empty element never runs
      end else if (run) begin
        if (x == width - 1'b1) begin
          x <= '0;
          if (y == height - 1'b1) run <= 1'b0;
          else y <= y + 1'b1;
        end else begin
          x <= x + 1'b1;
        end
      end
    end
  end

  assign finished = !run && !armed;

  assign sheet_x  = sprite_x + x;
  assign sheet_y  = sprite_y + y;
  assign rom_addr = ROM_AW'(sheet_y * SPRITE_WIDTH + sheet_x);

  // Match the two-cycle ROM latency
  always_ff @(posedge clk_33m) begin
    if (rst) begin
      v_d1 <= 1'b0;
      v_d2 <= 1'b0;
    end else begin
      v_d1 <= run;
      v_d2 <= v_d1;
    end
  end

  always_ff @(posedge clk_33m) begin
    x_d1 <= x;
    y_d1 <= y;
    x_d2 <= x_d1;
    y_d2 <= y_d1;
  end

  // Frame position of the pixel now leaving the ROM
  assign fx = frame_x + $signed({2'b00, x_d2});
  assign fy = frame_y + $signed({2'b00, y_d2});

  assign in_frame = (fx >= 0) && (fx < FRAME_WIDTH) &&
                    (fy >= 0) && (fy < FRAME_HEIGHT);

  always_ff @(posedge clk_33m) begin
    if (rst) wr_en <= 1'b0;
    else     wr_en <= v_d2 && in_frame; // Clipped pixels are dropped
  end

  always_ff @(posedge clk_33m) begin
    wr_addr <= FB_AW'(fy * FRAME_WIDTH + fx);
    wr_data <= rom_data;
  end

endmodule

// ==== sprite_rom.hex ====
// Sprite sheet, 16 rows of 32 palette entries
// Column is sheet x from 0 to 31, row is sheet y from 0 to 15
1 2 3 0 3 1 2 2 0 1 3 3 2 1 0 2 3 3 1 0 2 2 1 3 0 0 2 1 3 2 1 1
2 3 0 3 1 2 2 0 1 3 3 2 1 0 2 3 3 1 0 2 2 1 3 0 0 2 1 3 2 1 1 1
3 0 3 1 2 2 0 1 3 3 2 1 0 2 3 3 1 0 2 2 1 3 0 0 2 1 3 2 1 1 1 2
0 3 1 2 2 0 1 3 3 2 1 0 2 3 3 1 0 2 2 1 3 0 0 2 1 3 2 1 1 1 2 3
3 1 2 2 0 1 3 3 2 1 0 2 3 3 1 0 2 2 1 3 0 0 2 1 3 2 1 1 1 2 3 0
1 2 2 0 1 3 3 2 1 0 2 3 3 1 0 2 2 1 3 0 0 2 1 3 2 1 1 1 2 3 0 3
2 2 0 1 3 3 2 1 0 2 3 3 1 0 2 2 1 3 0 0 2 1 3 2 1 1 1 2 3 0 3 1
2 0 1 3 3 2 1 0 2 3 3 1 0 2 2 1 3 0 0 2 1 3 2 1 1 1 2 3 0 3 1 2
0 1 3 3 2 1 0 2 3 3 1 0 2 2 1 3 0 0 2 1 3 2 1 1 1 2 3 0 3 1 2 2
1 3 3 2 1 0 2 3 3 1 0 2 2 1 3 0 0 2 1 3 2 1 1 1 2 3 0 3 1 2 2 0
3 3 2 1 0 2 3 3 1 0 2 2 1 3 0 0 2 1 3 2 1 1 1 2 3 0 3 1 2 2 0 1
3 2 1 0 2 3 3 1 0 2 2 1 3 0 0 2 1 3 2 1 1 1 2 3 0 3 1 2 2 0 1 3
2 1 0 2 3 3 1 0 2 2 1 3 0 0 2 1 3 2 1 1 1 2 3 0 3 1 2 2 0 1 3 3
1 0 2 3 3 1 0 2 2 1 3 0 0 2 1 3 2 1 1 1 2 3 0 3 1 2 2 0 1 3 3 2
0 2 3 3 1 0 2 2 1 3 0 0 2 1 3 2 1 1 1 2 3 0 3 1 2 2 0 1 3 3 2 1
2 3 3 1 0 2 2 1 3 0 0 2 1 3 2 1 1 1 2 3 0 3 1 2 2 0 1 3 3 2 1 0

// ==== sprite_rom.sv ====
`timescale 1ns/1ps

module sprite_rom
  import dino_paint_pkg::*;
(
  input  logic                 clk_33m,
  input  logic [ROM_AW-1:0]    addr,
  output logic [PALETTE_W-1:0] data
);

  localparam int ROM_DEPTH = SPRITE_WIDTH * SPRITE_HEIGHT;

  logic [PALETTE_W-1:0] mem [ROM_DEPTH];
  logic [ROM_AW-1:0]    addr_q;

  // Sheet is stored row by row, SPRITE_WIDTH entries per row
  initial begin
    $readmemh("sprite_rom.hex", mem);
  end

  always_ff @(posedge clk_33m) begin
    addr_q <= addr;        // Input register
    data   <= mem[addr_q]; // Output register
  end

endmodule

// ==== tb_apb_tasks.svh ====
`ifndef TB_APB_TASKS_SVH
`define TB_APB_TASKS_SVH

localparam int XFER_TIMEOUT = 20;
localparam int POLL_TIMEOUT = 2000;

// One APB transfer, returns data, error flag and number of wait states
task automatic apb_xfer(input logic [15:0] addr, input logic write, input logic [31:0] wdata,
                        output logic [31:0] rdata, output logic err, output int waits);
  bit got;
  got   = 0;
  waits = 0;
  rdata = '0;
  err   = 1'b0;
  @(posedge clk_33m);
  psel    <= 1'b1;
  penable <= 1'b0;
  paddr   <= addr;
  pwrite  <= write;
  pwdata  <= wdata;
  @(posedge clk_33m);
  penable <= 1'b1;
  while (!got && waits < XFER_TIMEOUT) begin
    @(negedge clk_33m); // Outputs are settled here
    if (pready) begin
      got   = 1;
      rdata = prdata;
      err   = pslverr;
    end else begin
      waits++;
    end
  end
  if (!got) begin
    $display("APB transfer to address %h never completed", addr);
    errors++;
  end
  @(posedge clk_33m);
  psel    <= 1'b0;
  penable <= 1'b0;
endtask

task automatic apb_write(input logic [15:0] addr, input logic [31:0] wdata);
  logic [31:0] rd;
  logic        err;
  int          waits;
  apb_xfer(addr, 1'b1, wdata, rd, err, waits);
endtask

task automatic apb_read(input logic [15:0] addr, output logic [31:0] rdata);
  logic err;
  int   waits;
  apb_xfer(addr, 1'b0, '0, rdata, err, waits);
endtask

task automatic read_pixel(input int addr, output logic [31:0] pix);
  apb_read(FB_BASE | 16'(addr << 2), pix);
endtask

// Polls STATUS until busy is low, returns the last status word
task automatic wait_idle(output logic [31:0] status);
  int polls;
  polls  = 0;
  status = 32'h1;
  while (status[0] && polls < POLL_TIMEOUT) begin
    apb_read(REG_STATUS, status);
    polls++;
  end
  if (status[0]) begin
    $display("Painter stayed busy after %0d status reads", polls);
    errors++;
  end
endtask

`endif

// ==== tb_dino_paint.sv ====
`timescale 1ns/1ps

module tb_dino_paint
  import dino_paint_pkg::*;
;

  logic        clk_33m;
  logic        rst;
  logic [15:0] paddr;
  logic        psel;
  logic        penable;
  logic        pwrite;
  logic [31:0] pwdata;
  logic [31:0] prdata;
  logic        pready;
  logic        pslverr;

  int errors;
  int checks;
  int tests;

  logic [1:0] sheet [SPRITE_WIDTH*SPRITE_HEIGHT];
  logic [1:0] model [FRAME_WIDTH*FRAME_HEIGHT];

  dino_paint_top u_dut (
    .clk_33m (clk_33m),
    .rst     (rst),
    .paddr   (paddr),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .pwdata  (pwdata),
    .prdata  (prdata),
    .pready  (pready),
    .pslverr (pslverr)
  );

  `include "tb_apb_tasks.svh"

  always #20 clk_33m = ~clk_33m;

  // Bus responses only inside an access phase
  assert property (@(posedge clk_33m) disable iff (rst)
                   !(psel && penable) |-> (!pready && !pslverr))
    else begin
      $display("pready or pslverr high outside an access phase");
      errors++;
    end

  task automatic check_val(input string name, input int exp, input int act);
    checks++;
    assert (exp == act)
      else begin
        $display("Mismatch %s: expected %0d, actual %0d", name, exp, act);
        errors++;
      end
  endtask

  // Reference painting rule
  task automatic model_paint(input int sx, input int sy, input int fx, input int fy,
                             input int w, input int h);
    int px;
    int py;
    for (int y = 0; y < h; y++) begin
      for (int x = 0; x < w; x++) begin
        px = fx + x;
        py = fy + y;
        if (px >= 0 && px < FRAME_WIDTH && py >= 0 && py < FRAME_HEIGHT)
          model[py*FRAME_WIDTH + px] = sheet[(sy + y)*SPRITE_WIDTH + sx + x];
      end
    end
  endtask

  task automatic program_element(input int sx, input int sy, input int fx, input int fy,
                                 input int w, input int h);
    apb_write(REG_SPRITE_XY, {16'b0, 8'(sy), 8'(sx)});
    apb_write(REG_FRAME_XY, {7'b0, 9'(fy), 7'b0, 9'(fx)});
    apb_write(REG_SIZE, {16'b0, 8'(h), 8'(w)});
  endtask

  task automatic paint(input int sx, input int sy, input int fx, input int fy,
                       input int w, input int h);
    logic [31:0] st;
    program_element(sx, sy, fx, fy, w, h);
    apb_write(REG_CTRL, 32'h1);
    wait_idle(st);
    model_paint(sx, sy, fx, fy, w, h);
  endtask

  // Compares a frame window against the model within the frame edges
  task automatic compare_box(input string name, input int x0, input int y0,
                             input int x1, input int y1);
    logic [31:0] pix;
    for (int y = (y0 < 0 ? 0 : y0); y <= y1 && y < FRAME_HEIGHT; y++) begin
      for (int x = (x0 < 0 ? 0 : x0); x <= x1 && x < FRAME_WIDTH; x++) begin
        read_pixel(y*FRAME_WIDTH + x, pix);
        check_val($sformatf("%s pixel (%0d,%0d)", name, x, y), model[y*FRAME_WIDTH + x], pix);
      end
    end
  endtask

  task automatic end_test(input string name, input int err_before);
    tests++;
    $display("Test %s finished with %0d errors", name, errors - err_before);
  endtask

  initial begin
    logic [31:0] rd;
    logic        err;
    int          waits;
    int          e0;
    int          w;
    int          h;
    time         t_start;
    int          elapsed;
    clk_33m  = 1'b0;
    rst      = 1'b1;
    paddr    = '0;
    psel     = 1'b0;
    penable  = 1'b0;
    pwrite   = 1'b0;
    pwdata   = '0;
    errors   = 0;
    checks   = 0;
    tests    = 0;
    void'($urandom(32'h57ef6d0a));
    $readmemh("sprite_rom.hex", sheet);
    for (int i = 0; i < FRAME_WIDTH*FRAME_HEIGHT; i++) model[i] = '0;
    repeat (5) @(posedge clk_33m);
    rst <= 1'b0;

    e0 = errors;
    apb_read(REG_STATUS, rd);
    check_val("reset status", 0, rd);
    apb_read(REG_SPRITE_XY, rd);
    check_val("reset sprite_xy", 0, rd);
    apb_read(REG_FRAME_XY, rd);
    check_val("reset frame_xy", 0, rd);
    apb_read(REG_SIZE, rd);
    check_val("reset size", 0, rd);
    foreach (sheet[i]) if (i % 97 == 0) begin
      read_pixel(i * 16, rd);
      check_val("reset pixel", 0, rd);
    end
    end_test("reset", e0);

    e0 = errors;
    program_element(3, 2, 40, 20, 16, 8);
    apb_write(REG_CTRL, 32'h1);
    apb_read(REG_STATUS, rd);
    check_val("visible busy", 1, rd[0]);
    wait_idle(rd);
    check_val("visible done", 1, rd[1]);
    model_paint(3, 2, 40, 20, 16, 8);
    compare_box("visible", 38, 18, 57, 29);
    end_test("visible", e0);

    e0 = errors;
    paint(0, 0, -5, -3, 16, 8);
    paint(8, 4, 120, 60, 16, 8);
    paint(4, 2, -10, 58, 20, 10);
    paint(0, 0, -40, 10, 16, 8);
    compare_box("clip", 0, 0, FRAME_WIDTH - 1, FRAME_HEIGHT - 1);
    end_test("clip", e0);

    e0 = errors;
    program_element(1, 1, 60, 30, 20, 12);
    apb_write(REG_CTRL, 32'h1);
    t_start = $time;
    apb_write(REG_SIZE, 32'h0404);
    apb_write(REG_FRAME_XY, 32'h0);
    apb_write(REG_CTRL, 32'h1);
    apb_read(REG_SIZE, rd);
    check_val("busy size", 32'h0c14, rd);
    apb_read(REG_FRAME_XY, rd);
    check_val("busy frame_xy", {7'b0, 9'd30, 7'b0, 9'd60}, rd);
    wait_idle(rd);
    // Without a restart busy is seen low within w*h+5 cycles of the start
    elapsed = int'(($time - t_start) / 40);
    checks++;
    assert (elapsed <= 20 * 12 + 5)
      else begin
        $display("Second start restarted the painter, busy for %0d cycles", elapsed);
        errors++;
      end
    model_paint(1, 1, 60, 30, 20, 12);
    compare_box("busy", 0, 0, FRAME_WIDTH - 1, FRAME_HEIGHT - 1);
    end_test("busy", e0);

    e0 = errors;
    for (int n = 0; n < 8; n++) begin
      int sx;
      int sy;
      int fx;
      int fy;
      w  = 1 + $urandom % 16;
      h  = 1 + $urandom % 8;
      sx = $urandom % (SPRITE_WIDTH + 1 - w);
      sy = $urandom % (SPRITE_HEIGHT + 1 - h);
      fx = int'($urandom % (FRAME_WIDTH + 20)) - 10;
      fy = int'($urandom % (FRAME_HEIGHT + 10)) - 5;
      paint(sx, sy, fx, fy, w, h);
      compare_box($sformatf("random %0d", n), fx - 1, fy - 1, fx + w, fy + h);
    end
    end_test("random", e0);

    e0 = errors;
    apb_xfer(16'h0020, 1'b0, '0, rd, err, waits);
    check_val("unmapped read pslverr", 1, err);
    check_val("unmapped read data", 0, rd);
    apb_xfer(16'h0014, 1'b1, 32'h5, rd, err, waits);
    check_val("unmapped write pslverr", 1, err);
    apb_xfer(FB_BASE | 16'h0010, 1'b0, '0, rd, err, waits);
    check_val("pixel read waits", 1, waits);
    check_val("pixel read pslverr", 0, err);
    apb_xfer(REG_STATUS, 1'b0, '0, rd, err, waits);
    check_val("register read waits", 0, waits);
    apb_xfer(REG_SIZE, 1'b1, 32'h0, rd, err, waits);
    check_val("register write waits", 0, waits);
    check_val("register write pslverr", 0, err);
    end_test("bus", e0);

    $display("Ran %0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

  // Run limit
  initial begin
    int cycles;
    cycles = 0;
    while (cycles < 400000) begin
      @(posedge clk_33m);
      cycles++;
    end
    $display("Simulation ran out of time");
    $display("Checks failed");
    $finish;
  end

endmodule
